//--- common/icache_pkg.sv
// shared constants and the fill block type for the L1 instruction cache
// every cache module refers to these by scoped name

`default_nettype none

package icache_pkg;

    // ----------------------------------------
    // associativity

    // the one-bit LRU per set relies on two ways
    localparam int ASSOC     = 2;
    localparam int WAY_WIDTH = 1;

    // ----------------------------------------
    // block and fetch geometry

    // one fetch chunk is what the core consumes per lookup
    localparam int FETCH_BYTES = 16;
    localparam int BLOCK_BYTES = 32;

    localparam int CHUNKS_PER_BLOCK = BLOCK_BYTES / FETCH_BYTES;
    localparam int CHUNK_SEL_WIDTH  = 1;

    localparam int FETCH_BITS = FETCH_BYTES * 8;
    localparam int BLOCK_BITS = BLOCK_BYTES * 8;

    // physical address of a block, tag and index together
    localparam int BLOCK_ADDR_WIDTH = 29;

    // ----------------------------------------
    // fill block

    // L2 returns the whole block at once, the refill and the bypass
    // pick it apart one fetch chunk at a time
    typedef union packed {
        logic [BLOCK_BITS-1:0]                       whole;
        logic [CHUNKS_PER_BLOCK-1:0][FETCH_BITS-1:0] chunk;
    } fill_block_u;

endpackage

`default_nettype wire

//--- dv/icache_model.svh
// reference model for the instruction cache testbench
// memory pattern per block address plus tags, valid bits and LRU of each set
`ifndef ICACHE_MODEL_SVH
`define ICACHE_MODEL_SVH

// ----------------------------------------
// memory contents

localparam logic [31:0] PATTERN_MASK = 32'ha5c3_0f96;

// every 32-bit word carries its block address and word number
function automatic logic [icache_pkg::FETCH_BITS-1:0] chunk_pattern(
    input logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] block_addr,
    input int chunk
);
    logic [icache_pkg::FETCH_BITS-1:0] data;
    for (int k = 0; k < 4; k++) begin
        data[32*k +: 32] = {block_addr, 3'(chunk * 4 + k)} ^ PATTERN_MASK;
    end
    return data;
endfunction

function automatic logic [icache_pkg::BLOCK_BITS-1:0] block_pattern(
    input logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] block_addr
);
    logic [icache_pkg::BLOCK_BITS-1:0] block;
    for (int c = 0; c < icache_pkg::CHUNKS_PER_BLOCK; c++) begin
        block[icache_pkg::FETCH_BITS*c +: icache_pkg::FETCH_BITS] = chunk_pattern(block_addr, c);
    end
    return block;
endfunction

// ----------------------------------------
// set state

logic                             model_valid [NUM_SETS][icache_pkg::ASSOC];
logic [TAG_WIDTH-1:0]             model_tag   [NUM_SETS][icache_pkg::ASSOC];
logic [icache_pkg::WAY_WIDTH-1:0] model_lru   [NUM_SETS];

// lowest empty way, otherwise the least recently used one
function automatic logic [icache_pkg::WAY_WIDTH-1:0] model_victim(
    input logic [INDEX_WIDTH-1:0] idx
);
    logic [icache_pkg::WAY_WIDTH-1:0] way;
    way = model_lru[idx];
    for (int w = icache_pkg::ASSOC - 1; w >= 0; w--) begin
        if (!model_valid[idx][w]) begin
            way = icache_pkg::WAY_WIDTH'(w);
        end
    end
    return way;
endfunction

`endif

//--- dv/icache_tb.sv
// testbench for the two-way instruction cache
// random core and L2 agents, responses checked against the model

`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int NUM_SETS    = 128;
    localparam int INDEX_WIDTH = $clog2(NUM_SETS);
    localparam int TAG_WIDTH   = icache_pkg::BLOCK_ADDR_WIDTH - INDEX_WIDTH;
    localparam int NUM_TRANS   = 200;
    localparam int CYCLE_LIMIT = NUM_TRANS * 40;

    localparam logic [15:0]          LFSR_SEED = 16'd46973;
    localparam logic [15:0]          LFSR_TAPS = 16'hb400;
    localparam logic [TAG_WIDTH-1:0] TAG_BASE  = 22'h2c5a0;

    `include "icache_model.svh"

    logic CLK;
    logic nRST;
    logic                                   core_req_valid;
    logic [INDEX_WIDTH-1:0]                 core_req_index;
    logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] core_req_chunk;
    logic [icache_pkg::ASSOC-1:0]                             core_resp_valid_by_way;
    logic [icache_pkg::ASSOC-1:0][TAG_WIDTH-1:0]              core_resp_tag_by_way;
    logic [icache_pkg::ASSOC-1:0][icache_pkg::FETCH_BITS-1:0] core_resp_instr_by_way;
    logic                             core_resp_hit_valid;
    logic [icache_pkg::WAY_WIDTH-1:0] core_resp_hit_way;
    logic                             core_resp_miss_valid;
    logic [TAG_WIDTH-1:0]             core_resp_miss_tag;
    logic                                    l2_req_valid;
    logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] l2_req_block_addr;
    logic                                    l2_req_ready;
    logic                                    l2_resp_valid;
    logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] l2_resp_block_addr;
    logic [icache_pkg::BLOCK_BITS-1:0]       l2_resp_block;

    logic                                    resp_pending;
    logic [TAG_WIDTH-1:0]                    cur_tag;
    logic [icache_pkg::ASSOC-1:0]            hit_match;
    logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] expected_block_addr;
    logic [15:0] core_lfsr;
    logic [15:0] l2_lfsr;
    int          cycle_count;

    icache_top #(.NUM_SETS(NUM_SETS)) icache_top_i (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ----------------------------------------
    // helpers

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(inout logic [15:0] state, input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s got %h expected %h", name, got, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // core compares tags itself and feeds back in the response cycle
    always_comb begin
        for (int w = 0; w < icache_pkg::ASSOC; w++) begin
            hit_match[w] = resp_pending && core_resp_valid_by_way[w]
                && (core_resp_tag_by_way[w] == cur_tag);
        end
    end

    assign core_resp_hit_valid  = |hit_match;
    assign core_resp_hit_way    = hit_match[1];
    assign core_resp_miss_valid = resp_pending && !(|hit_match);
    assign core_resp_miss_tag   = cur_tag;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the cache did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // ----------------------------------------
    // core agent

    task automatic issue(input logic [INDEX_WIDTH-1:0] idx, input logic [TAG_WIDTH-1:0] tag,
                         input logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] chunk);
        @(posedge CLK);
        resp_pending   <= 1'b0;
        core_req_valid <= 1'b1;
        core_req_index <= idx;
        core_req_chunk <= chunk;
        @(posedge CLK);
        core_req_valid <= 1'b0;
        resp_pending   <= 1'b1;
        cur_tag        <= tag;
        @(negedge CLK);
    endtask

    task automatic check_response(input logic [INDEX_WIDTH-1:0] idx,
                                  input logic [TAG_WIDTH-1:0] tag,
                                  input logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] chunk);
        logic                             exp_hit;
        logic [icache_pkg::WAY_WIDTH-1:0] exp_way;
        exp_hit = 1'b0;
        exp_way = '0;
        for (int w = 0; w < icache_pkg::ASSOC; w++) begin
            check_value($sformatf("core_resp_valid_by_way[%0d]", w),
                        core_resp_valid_by_way[w], model_valid[idx][w]);
            if (model_valid[idx][w]) begin
                check_value($sformatf("core_resp_tag_by_way[%0d]", w),
                            core_resp_tag_by_way[w], model_tag[idx][w]);
                if (model_tag[idx][w] == tag) begin
                    exp_hit = 1'b1;
                    exp_way = icache_pkg::WAY_WIDTH'(w);
                    check_value($sformatf("core_resp_instr_by_way[%0d]", w),
                                core_resp_instr_by_way[w], chunk_pattern({tag, idx}, chunk));
                end
            end
        end
        if (exp_hit) begin
            model_lru[idx] = ~exp_way;
        end
    endtask

    task automatic run_transaction();
        logic [INDEX_WIDTH-1:0]                 idx;
        logic [TAG_WIDTH-1:0]                   tag;
        logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] chunk;
        logic [icache_pkg::WAY_WIDTH-1:0]       victim;
        // a small pool of sets and tags forces replacements
        idx   = INDEX_WIDTH'(rand_bits(core_lfsr, 2) * 37 + 13);
        tag   = TAG_BASE | TAG_WIDTH'(rand_bits(core_lfsr, 2));
        chunk = icache_pkg::CHUNK_SEL_WIDTH'(rand_bits(core_lfsr, 1));
        issue(idx, tag, chunk);
        check_response(idx, tag, chunk);
        if (!core_resp_hit_valid) begin
            victim              = model_victim(idx);
            model_lru[idx]      = ~victim;
            expected_block_addr = {tag, idx};
            // retry until the fill shows up in the bypass or in the arrays
            do begin
                issue(idx, tag, chunk);
                if (core_resp_hit_valid) begin
                    model_valid[idx][victim] = 1'b1;
                    model_tag[idx][victim]   = tag;
                end
                check_response(idx, tag, chunk);
            end while (!core_resp_hit_valid);
        end
    endtask

    initial begin
        nRST                = 1'b0;
        core_req_valid      = 1'b0;
        core_req_index      = '0;
        core_req_chunk      = '0;
        resp_pending        = 1'b0;
        cur_tag             = '0;
        l2_req_ready        = 1'b0;
        l2_resp_valid       = 1'b0;
        l2_resp_block_addr  = '0;
        l2_resp_block       = '0;
        expected_block_addr = '0;
        core_lfsr           = LFSR_SEED;
        l2_lfsr             = LFSR_SEED;
        cycle_count         = 0;
        for (int s = 0; s < NUM_SETS; s++) begin
            model_lru[s] = '0;
            for (int w = 0; w < icache_pkg::ASSOC; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_value("core_resp_valid_by_way", core_resp_valid_by_way, '0);
        check_value("l2_req_valid", l2_req_valid, 1'b0);
        for (int t = 0; t < NUM_TRANS; t++) begin
            run_transaction();
        end
        @(posedge CLK);
        resp_pending <= 1'b0;
        repeat (2) @(posedge CLK);
        $display("TEST PASSED");
        $finish;
    end

    // ----------------------------------------
    // L2 agent

    initial begin
        int delay;
        int latency;
        @(posedge nRST);
        forever begin
            @(negedge CLK);
            if (l2_req_valid) begin
                check_value("l2_req_block_addr", l2_req_block_addr, expected_block_addr);
                delay = int'(rand_bits(l2_lfsr, 2));
                // the request holds while ready stays low
                repeat (delay) begin
                    @(negedge CLK);
                    check_value("l2_req_valid", l2_req_valid, 1'b1);
                    check_value("l2_req_block_addr", l2_req_block_addr, expected_block_addr);
                end
                @(posedge CLK);
                l2_req_ready <= 1'b1;
                @(posedge CLK);
                l2_req_ready <= 1'b0;
                latency = int'(rand_bits(l2_lfsr, 3)) + 1;
                repeat (latency - 1) @(posedge CLK);
                l2_resp_valid      <= 1'b1;
                l2_resp_block_addr <= expected_block_addr;
                l2_resp_block      <= block_pattern(expected_block_addr);
                @(posedge CLK);
                l2_resp_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- icache.f
+incdir+dv
common/icache_pkg.sv
icache/icache_arrays.sv
icache/icache_lookup.sv
icache/icache_miss_unit.sv
icache/icache_top.sv
dv/icache_tb.sv

//--- icache/icache_arrays.sv
// tag, valid, data and LRU storage for the instruction cache
// one synchronous read port, one write port with per-way enables

`timescale 1ns/1ps
`default_nettype none

module icache_arrays #(
    parameter  int NUM_SETS    = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH   = icache_pkg::BLOCK_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic CLK,
    input  logic nRST,

    // read port
    input  logic                                                     rd_en,
    input  logic [INDEX_WIDTH-1:0]                                   rd_index,
    input  logic [icache_pkg::CHUNK_SEL_WIDTH-1:0]                   rd_chunk,
    output logic [icache_pkg::ASSOC-1:0]                             rd_valid_by_way,
    output logic [icache_pkg::ASSOC-1:0][TAG_WIDTH-1:0]              rd_tag_by_way,
    output logic [icache_pkg::ASSOC-1:0][icache_pkg::FETCH_BITS-1:0] rd_data_by_way,

    // write port
    input  logic [icache_pkg::ASSOC-1:0]           wr_en_by_way,
    input  logic [INDEX_WIDTH-1:0]                 wr_index,
    input  logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] wr_chunk,
    input  logic [TAG_WIDTH-1:0]                   wr_tag,
    input  logic                                   wr_valid,
    input  logic                                   wr_tag_en,
    input  logic [icache_pkg::FETCH_BITS-1:0]      wr_data,

    // LRU
    input  logic                             lru_touch_valid,
    input  logic [INDEX_WIDTH-1:0]           lru_touch_index,
    input  logic [icache_pkg::WAY_WIDTH-1:0] lru_touch_way,
    input  logic                             lru_new_valid,
    input  logic [INDEX_WIDTH-1:0]           lru_new_index,
    input  logic [icache_pkg::WAY_WIDTH-1:0] lru_new_way,
    input  logic [INDEX_WIDTH-1:0]           lru_rd_index,
    output logic [icache_pkg::WAY_WIDTH-1:0] lru_way
);

    localparam int DATA_DEPTH = NUM_SETS * icache_pkg::CHUNKS_PER_BLOCK;

    logic [TAG_WIDTH-1:0]              tag_mem  [icache_pkg::ASSOC][NUM_SETS];
    logic [icache_pkg::FETCH_BITS-1:0] data_mem [icache_pkg::ASSOC][DATA_DEPTH];

    logic [NUM_SETS-1:0][icache_pkg::ASSOC-1:0] valid_q;

    // bit holds the least recently used way of the set
    logic [NUM_SETS-1:0] lru_q;

    // ----------------------------------------
    // valid bits and LRU

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q         <= '0;
            lru_q           <= '0;
            rd_valid_by_way <= '0;
        end else begin
            // read sees the value from before this edge's write
            if (rd_en) begin
                rd_valid_by_way <= valid_q[rd_index];
            end
            for (int w = 0; w < icache_pkg::ASSOC; w++) begin
                if (wr_en_by_way[w] && wr_tag_en) begin
                    valid_q[wr_index][w] <= wr_valid;
                end
            end
            // point away from the used way, allocation wins
            if (lru_touch_valid) begin
                lru_q[lru_touch_index] <= ~lru_touch_way;
            end
            if (lru_new_valid) begin
                lru_q[lru_new_index] <= ~lru_new_way;
            end
        end
    end

    assign lru_way = lru_q[lru_rd_index];

    // ----------------------------------------
    // tag and data memories

    always_ff @(posedge CLK) begin
        for (int w = 0; w < icache_pkg::ASSOC; w++) begin
            if (wr_en_by_way[w]) begin
                data_mem[w][{wr_index, wr_chunk}] <= wr_data;
                if (wr_tag_en) begin
                    tag_mem[w][wr_index] <= wr_tag;
                end
            end
            if (rd_en) begin
                rd_tag_by_way[w]  <= tag_mem[w][rd_index];
                rd_data_by_way[w] <= data_mem[w][{rd_index, rd_chunk}];
            end
        end
    end

    // refill targets a single victim way
    wr_onehot_a: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0(wr_en_by_way));

endmodule

`default_nettype wire

//--- icache/icache_lookup.sv
// lookup stage of the instruction cache
// registers the core request, builds the per-way response and the LRU touch

`timescale 1ns/1ps
`default_nettype none

module icache_lookup #(
    parameter  int NUM_SETS    = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH   = icache_pkg::BLOCK_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic CLK,
    input  logic nRST,

    // core request
    input  logic                                   core_req_valid,
    input  logic [INDEX_WIDTH-1:0]                 core_req_index,
    input  logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] core_req_chunk,

    // array read port
    output logic                                                     rd_en,
    output logic [INDEX_WIDTH-1:0]                                   rd_index,
    output logic [icache_pkg::CHUNK_SEL_WIDTH-1:0]                   rd_chunk,
    input  logic [icache_pkg::ASSOC-1:0]                             rd_valid_by_way,
    input  logic [icache_pkg::ASSOC-1:0][TAG_WIDTH-1:0]              rd_tag_by_way,
    input  logic [icache_pkg::ASSOC-1:0][icache_pkg::FETCH_BITS-1:0] rd_data_by_way,

    // core response and feedback
    output logic [icache_pkg::ASSOC-1:0]                             core_resp_valid_by_way,
    output logic [icache_pkg::ASSOC-1:0][TAG_WIDTH-1:0]              core_resp_tag_by_way,
    output logic [icache_pkg::ASSOC-1:0][icache_pkg::FETCH_BITS-1:0] core_resp_instr_by_way,
    input  logic                                                     core_resp_hit_valid,
    input  logic [icache_pkg::WAY_WIDTH-1:0]                         core_resp_hit_way,
    input  logic                                                     core_resp_miss_valid,

    // LRU touch
    output logic                             lru_touch_valid,
    output logic [INDEX_WIDTH-1:0]           lru_touch_index,
    output logic [icache_pkg::WAY_WIDTH-1:0] lru_touch_way,

    // bypass status from the miss unit
    input  logic                             fill_visible,
    input  logic [INDEX_WIDTH-1:0]           miss_index,
    input  logic [TAG_WIDTH-1:0]             miss_tag,
    input  logic [icache_pkg::WAY_WIDTH-1:0] victim_way,
    input  icache_pkg::fill_block_u          fill_block,

    output logic [INDEX_WIDTH-1:0] resp_index
);

    logic                                   req_valid_q;
    logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] resp_chunk;
    logic                                   bypass_hit;

    // the request goes straight into the array read port
    assign rd_en    = core_req_valid;
    assign rd_index = core_req_index;
    assign rd_chunk = core_req_chunk;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= core_req_valid;
        end
    end

    always_ff @(posedge CLK) begin
        resp_index <= core_req_index;
        resp_chunk <= core_req_chunk;
    end

    // ----------------------------------------
    // response assembly

    // only the index has to match, the victim way takes the miss tag
    assign bypass_hit = req_valid_q && fill_visible && (resp_index == miss_index);

    always_comb begin
        core_resp_valid_by_way = rd_valid_by_way;
        core_resp_tag_by_way   = rd_tag_by_way;
        core_resp_instr_by_way = rd_data_by_way;
        if (bypass_hit) begin
            core_resp_valid_by_way[victim_way] = 1'b1;
            core_resp_tag_by_way[victim_way]   = miss_tag;
            core_resp_instr_by_way[victim_way] = fill_block.chunk[resp_chunk];
        end
    end

    // hit feedback refers to the registered request
    assign lru_touch_valid = core_resp_hit_valid;
    assign lru_touch_index = resp_index;
    assign lru_touch_way   = core_resp_hit_way;

    feedback_a: assert property (@(posedge CLK) disable iff (!nRST)
        (core_resp_hit_valid || core_resp_miss_valid)
            |-> req_valid_q && !(core_resp_hit_valid && core_resp_miss_valid));

endmodule

`default_nettype wire

//--- icache/icache_miss_unit.sv
// miss unit of the instruction cache
// holds the one miss, requests the block from L2 and refills chunk by chunk

`timescale 1ns/1ps
`default_nettype none

module icache_miss_unit #(
    parameter  int NUM_SETS    = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH   = icache_pkg::BLOCK_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic CLK,
    input  logic nRST,

    // miss feedback and the set it refers to
    input  logic                             core_resp_miss_valid,
    input  logic [TAG_WIDTH-1:0]             core_resp_miss_tag,
    input  logic [INDEX_WIDTH-1:0]           resp_index,
    input  logic [icache_pkg::ASSOC-1:0]     rd_valid_by_way,
    input  logic [icache_pkg::WAY_WIDTH-1:0] lru_way,
    output logic [INDEX_WIDTH-1:0]           lru_rd_index,

    // L2
    output logic                                    l2_req_valid,
    output logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] l2_req_block_addr,
    input  logic                                    l2_req_ready,
    input  logic                                    l2_resp_valid,
    input  logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] l2_resp_block_addr,
    input  logic [icache_pkg::BLOCK_BITS-1:0]       l2_resp_block,

    // array write port
    output logic [icache_pkg::ASSOC-1:0]           wr_en_by_way,
    output logic [INDEX_WIDTH-1:0]                 wr_index,
    output logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] wr_chunk,
    output logic [TAG_WIDTH-1:0]                   wr_tag,
    output logic                                   wr_valid,
    output logic                                   wr_tag_en,
    output logic [icache_pkg::FETCH_BITS-1:0]      wr_data,

    // LRU allocation
    output logic                             lru_new_valid,
    output logic [INDEX_WIDTH-1:0]           lru_new_index,
    output logic [icache_pkg::WAY_WIDTH-1:0] lru_new_way,

    // bypass status
    output logic                             fill_visible,
    output logic [INDEX_WIDTH-1:0]           miss_index,
    output logic [TAG_WIDTH-1:0]             miss_tag,
    output logic [icache_pkg::WAY_WIDTH-1:0] victim_way,
    output icache_pkg::fill_block_u          fill_block
);

    logic                                   miss_valid;
    logic                                   requested;
    logic                                   fill_valid;
    logic                                   delay_cycle;
    logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] fill_chunk;

    logic                             capture;
    logic                             accept;
    logic                             last_chunk;
    logic [icache_pkg::ASSOC-1:0]     set_valid;
    logic [icache_pkg::WAY_WIDTH-1:0] new_victim;

    // ----------------------------------------
    // miss capture and victim choice

    assign lru_rd_index = resp_index;
    assign last_chunk   = (fill_chunk == '1);

    // a same-address miss while waiting is the core retrying
    assign capture = core_resp_miss_valid && !fill_valid
        && !(miss_valid && resp_index == miss_index && core_resp_miss_tag == miss_tag);

    // victim is the lowest empty way
    // a way in its delay cycle already counts as filled
    always_comb begin
        set_valid = rd_valid_by_way;
        if (fill_visible && resp_index == miss_index) begin
            set_valid[victim_way] = 1'b1;
        end
        new_victim = lru_way;
        for (int w = icache_pkg::ASSOC - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                new_victim = icache_pkg::WAY_WIDTH'(w);
            end
        end
    end

    assign lru_new_valid = capture;
    assign lru_new_index = resp_index;
    assign lru_new_way   = new_victim;

    // ----------------------------------------
    // L2 request and response

    assign l2_req_valid      = miss_valid && !requested;
    assign l2_req_block_addr = {miss_tag, miss_index};

    assign accept = l2_resp_valid && miss_valid && !fill_valid && !delay_cycle && !capture
        && (l2_resp_block_addr == {miss_tag, miss_index});

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            miss_valid  <= 1'b0;
            requested   <= 1'b0;
            fill_valid  <= 1'b0;
            delay_cycle <= 1'b0;
            fill_chunk  <= '0;
        end else if (fill_valid) begin
            fill_chunk <= fill_chunk + 1'b1;
            if (last_chunk) begin
                fill_valid  <= 1'b0;
                delay_cycle <= 1'b1;
            end
        end else if (capture) begin
            miss_valid  <= 1'b1;
            requested   <= 1'b0;
            delay_cycle <= 1'b0;
            fill_chunk  <= '0;
        end else if (delay_cycle) begin
            miss_valid  <= 1'b0;
            delay_cycle <= 1'b0;
        end else if (accept) begin
            // a response may beat the ready
            requested  <= 1'b1;
            fill_valid <= 1'b1;
        end else if (l2_req_valid && l2_req_ready) begin
            requested <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            miss_index <= resp_index;
            miss_tag   <= core_resp_miss_tag;
            victim_way <= new_victim;
        end
        if (accept) begin
            fill_block.whole <= l2_resp_block;
        end
    end

    // ----------------------------------------
    // refill write and bypass status

    assign wr_en_by_way = fill_valid ? icache_pkg::ASSOC'(1) << victim_way : '0;
    assign wr_index     = miss_index;
    assign wr_chunk     = fill_chunk;
    assign wr_tag       = miss_tag;
    // the first chunk drops the old line and the last one validates the new line
    assign wr_tag_en    = fill_valid;
    assign wr_valid     = last_chunk;
    assign wr_data      = fill_block.chunk[fill_chunk];

    assign fill_visible = miss_valid && (fill_valid || delay_cycle);

    req_stable_a: assert property (@(posedge CLK) disable iff (!nRST)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_block_addr));

    // the counter rests at the first chunk whenever no block is held
    chunk_move_a: assert property (@(posedge CLK) disable iff (!nRST)
        !fill_valid |-> fill_chunk == '0);

endmodule

`default_nettype wire

//--- icache/icache_top.sv
// L1 instruction cache top, two-way set associative and blocking
// connects the lookup stage, the storage arrays and the miss unit

`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter  int NUM_SETS    = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH   = icache_pkg::BLOCK_ADDR_WIDTH - INDEX_WIDTH
) (
    input  logic CLK,
    input  logic nRST,

    // core request
    input  logic                                  core_req_valid,
    input  logic [INDEX_WIDTH-1:0]                core_req_index,
    input  logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] core_req_chunk,

    // core response and same-cycle feedback
    output logic [icache_pkg::ASSOC-1:0]                             core_resp_valid_by_way,
    output logic [icache_pkg::ASSOC-1:0][TAG_WIDTH-1:0]              core_resp_tag_by_way,
    output logic [icache_pkg::ASSOC-1:0][icache_pkg::FETCH_BITS-1:0] core_resp_instr_by_way,
    input  logic                                                     core_resp_hit_valid,
    input  logic [icache_pkg::WAY_WIDTH-1:0]                         core_resp_hit_way,
    input  logic                                                     core_resp_miss_valid,
    input  logic [TAG_WIDTH-1:0]                                     core_resp_miss_tag,

    // L2 request
    output logic                                    l2_req_valid,
    output logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] l2_req_block_addr,
    input  logic                                    l2_req_ready,

    // L2 response
    input  logic                                    l2_resp_valid,
    input  logic [icache_pkg::BLOCK_ADDR_WIDTH-1:0] l2_resp_block_addr,
    input  logic [icache_pkg::BLOCK_BITS-1:0]       l2_resp_block
);

    // ----------------------------------------
    // internal wires

    logic                                   rd_en;
    logic [INDEX_WIDTH-1:0]                 rd_index;
    logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] rd_chunk;

    logic [icache_pkg::ASSOC-1:0]                             rd_valid_by_way;
    logic [icache_pkg::ASSOC-1:0][TAG_WIDTH-1:0]              rd_tag_by_way;
    logic [icache_pkg::ASSOC-1:0][icache_pkg::FETCH_BITS-1:0] rd_data_by_way;

    logic [icache_pkg::ASSOC-1:0]           wr_en_by_way;
    logic [INDEX_WIDTH-1:0]                 wr_index;
    logic [icache_pkg::CHUNK_SEL_WIDTH-1:0] wr_chunk;
    logic [TAG_WIDTH-1:0]                   wr_tag;
    logic                                   wr_valid;
    logic                                   wr_tag_en;
    logic [icache_pkg::FETCH_BITS-1:0]      wr_data;

    logic                             lru_touch_valid;
    logic [INDEX_WIDTH-1:0]           lru_touch_index;
    logic [icache_pkg::WAY_WIDTH-1:0] lru_touch_way;
    logic                             lru_new_valid;
    logic [INDEX_WIDTH-1:0]           lru_new_index;
    logic [icache_pkg::WAY_WIDTH-1:0] lru_new_way;
    logic [INDEX_WIDTH-1:0]           lru_rd_index;
    logic [icache_pkg::WAY_WIDTH-1:0] lru_way;

    // bypass status from the miss unit
    logic                             fill_visible;
    logic [INDEX_WIDTH-1:0]           miss_index;
    logic [TAG_WIDTH-1:0]             miss_tag;
    logic [icache_pkg::WAY_WIDTH-1:0] victim_way;
    icache_pkg::fill_block_u          fill_block;

    logic [INDEX_WIDTH-1:0] resp_index;

    // ----------------------------------------
    // blocks

    icache_lookup #(.NUM_SETS(NUM_SETS)) icache_lookup_i (.*);

    icache_arrays #(.NUM_SETS(NUM_SETS)) icache_arrays_i (.*);

    icache_miss_unit #(.NUM_SETS(NUM_SETS)) icache_miss_unit_i (.*);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds the instruction cache testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
OBJ_DIR="$BUILD_DIR/obj_dir"
LOG="$BUILD_DIR/sim.log"

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "could not create $BUILD_DIR"
    exit 1
fi

verilator --binary --timing --assert -Wno-fatal \
    --top-module icache_tb -Mdir "$OBJ_DIR" -f icache.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$OBJ_DIR/Vicache_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $LOG"
exit 1
